//--- data_mem.sv
// --------------------------------------------------
// Data memory with byte-enabled writes and an atomic unit
// --------------------------------------------------
module data_mem #(
    parameter int MEM_WORDS = 256                       // Depth in 64-bit words
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      access_i,         // One-cycle access strobe
    dmem_req_if.mem                   req,
    output logic                      rsp_valid_o,
    output logic [dmem_pkg::XLEN-1:0] rdata_o           // Old word
);
    import dmem_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [XLEN-1:0]  mem_q [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic [XLEN-1:0]  old_word;
    logic [31:0]      old_lane, src_lane;
    logic [XLEN-1:0]  opa, opb;                         // Extended operands
    logic [XLEN-1:0]  amo_res;
    logic [XLEN-1:0]  new_word;
    logic             rsp_valid_q;
    logic [XLEN-1:0]  rdata_q;

    // Array starts out cleared
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_q[i] = '0;
        end
    end

    assign idx      = req.addr[IDX_W+2:3];
    assign old_word = mem_q[idx];

    // --------------------------------------------------
    // Atomic unit
    // --------------------------------------------------
    always_comb begin
        old_lane = req.addr[2] ? old_word[63:32] : old_word[31:0];
        src_lane = req.addr[2] ? req.wdata[63:32] : req.wdata[31:0];
        // Sign extension keeps both signed and unsigned order
        opa = req.word ? {{32{old_lane[31]}}, old_lane} : old_word;
        opb = req.word ? {{32{src_lane[31]}}, src_lane} : req.wdata;
        case (req.op)
            AMO_ADD:  amo_res = opa + opb;
            AMO_XOR:  amo_res = opa ^ opb;
            AMO_AND:  amo_res = opa & opb;
            AMO_OR:   amo_res = opa | opb;
            AMO_MIN:  amo_res = ($signed(opa) < $signed(opb)) ? opa : opb;
            AMO_MAX:  amo_res = ($signed(opa) > $signed(opb)) ? opa : opb;
            AMO_MINU: amo_res = (opa < opb) ? opa : opb;
            AMO_MAXU: amo_res = (opa > opb) ? opa : opb;
            default:  amo_res = opb;                    // Swap and plain store
        endcase
        new_word = req.word ? {2{amo_res[31:0]}} : amo_res;   // be picks the lane
    end

    // Read old word, write under byte enable
    always_ff @(posedge clk_i) begin
        if (access_i) begin
            rdata_q <= old_word;
            for (int b = 0; b < 8; b++) begin
                if (req.be[b]) begin
                    mem_q[idx][8*b +: 8] <= new_word[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= access_i;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rdata_o     = rdata_q;

endmodule

//--- dcache_interface.sv
// --------------------------------------------------
// Latches a CPU memory request and turns it into a cache request
// --------------------------------------------------
module dcache_interface (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        capture_i,      // From control, one cycle
    input  dmem_pkg::mem_instr_e        instr_i,
    input  logic [dmem_pkg::ADDR_W-1:0] addr_i,
    input  logic [dmem_pkg::XLEN-1:0]   wdata_i,
    input  logic [dmem_pkg::TAG_W-1:0]  rd_i,
    input  logic [dmem_pkg::ADDR_W-1:0] io_base_i,
    input  logic                        xlate_en_i,     // Translation on
    output logic                        io_o,           // Uncacheable access
    dmem_req_if.src                     req
);
    import dmem_pkg::*;

    localparam logic [ADDR_W-1:0] IO_LIMIT = {{(ADDR_W-32){1'b0}}, IO_TOP};

    mem_instr_e        instr_q;
    logic [ADDR_W-1:0] addr_q;
    logic [XLEN-1:0]   wdata_q;
    logic [TAG_W-1:0]  rd_q;
    logic              io_q;
    logic              io_hit;

    // I/O window only applies with translation off
    assign io_hit = (addr_i >= io_base_i) && (addr_i < IO_LIMIT) && !xlate_en_i;

    // Request payload
    always_ff @(posedge clk_i) begin
        if (capture_i) begin
            instr_q <= instr_i;
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
            rd_q    <= rd_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            io_q <= 1'b0;
        end else if (capture_i) begin
            io_q <= io_hit;                     // Held until next request
        end
    end

    assign io_o     = io_q;
    assign req.addr = addr_q;
    assign req.tag  = rd_q;

    // --------------------------------------------------
    // Instruction decode
    // --------------------------------------------------
    always_comb begin
        req.op   = LOAD;
        req.size = 2'd3;
        req.sign = 1'b0;
        req.word = 1'b0;
        case (instr_q)
            LB:  begin req.size = 2'd0; req.sign = 1'b1; end
            LBU: req.size = 2'd0;
            LH:  begin req.size = 2'd1; req.sign = 1'b1; end
            LHU: req.size = 2'd1;
            LW:  begin req.size = 2'd2; req.sign = 1'b1; end
            LWU: req.size = 2'd2;
            LD:  req.size = 2'd3;
            SB:  begin req.op = STORE; req.size = 2'd0; end
            SH:  begin req.op = STORE; req.size = 2'd1; end
            SW:  begin req.op = STORE; req.size = 2'd2; end
            SD:  req.op = STORE;
            AMO_SWAPW, AMO_SWAPD: req.op = AMO_SWAP;
            AMO_ADDW,  AMO_ADDD:  req.op = AMO_ADD;
            AMO_XORW,  AMO_XORD:  req.op = AMO_XOR;
            AMO_ANDW,  AMO_ANDD:  req.op = AMO_AND;
            AMO_ORW,   AMO_ORD:   req.op = AMO_OR;
            AMO_MINW,  AMO_MIND:  req.op = AMO_MIN;
            AMO_MAXW,  AMO_MAXD:  req.op = AMO_MAX;
            AMO_MINWU, AMO_MINDU: req.op = AMO_MINU;
            AMO_MAXWU, AMO_MAXDU: req.op = AMO_MAXU;
            default: req.op = LOAD;
        endcase
        // W-form atomics work on one 32-bit lane and sign-extend
        case (instr_q)
            AMO_SWAPW, AMO_ADDW, AMO_XORW, AMO_ANDW, AMO_ORW,
            AMO_MINW, AMO_MAXW, AMO_MINWU, AMO_MAXWU: begin
                req.word = 1'b1;
                req.size = 2'd2;
                req.sign = 1'b1;
            end
            default: ;
        endcase
    end

    // Byte enable and lane shift
    always_comb begin
        case (req.size)
            2'd0: begin
                req.be    = 8'b0000_0001 << addr_q[2:0];
                req.wdata = wdata_q << {addr_q[2:0], 3'b0};
            end
            2'd1: begin
                req.be    = 8'b0000_0011 << {addr_q[2:1], 1'b0};
                req.wdata = wdata_q << {addr_q[2:1], 4'b0};
            end
            2'd2: begin
                req.be    = 8'b0000_1111 << {addr_q[2], 2'b0};
                req.wdata = wdata_q << {addr_q[2], 5'b0};
            end
            default: begin
                req.be    = 8'hff;
                req.wdata = wdata_q;
            end
        endcase
        if (req.op == LOAD) begin
            req.be    = '0;                     // Nothing written on a load
            req.wdata = '0;
        end
    end

endmodule

//--- dmem_ctrl.sv
// --------------------------------------------------
// Four-phase handshake and access sequencing, event pulses
// --------------------------------------------------
module dmem_ctrl (
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    req_i,                      // CPU request
    output logic    ack_o,                      // Result valid
    output logic    capture_o,                  // Latch request inputs
    output logic    access_o,                   // Start memory access
    input  logic    rsp_valid_i,
    dmem_req_if.mon req,
    output logic    is_load_o,
    output logic    is_store_o
);
    import dmem_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    // --------------------------------------------------
    // State machine
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_i) begin
                    state_d = ISSUE;            // Request captured this edge
                end
            end
            ISSUE: begin
                state_d = RESP;
            end
            RESP: begin
                if (rsp_valid_i) begin
                    state_d = ACK;
                end
            end
            ACK: begin
                if (!req_i) begin
                    state_d = IDLE;             // CPU released the request
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Strobes to the datapath
    assign capture_o = (state_q == IDLE) && req_i;
    assign access_o  = (state_q == ISSUE);      // Latched request is on req
    assign ack_o     = (state_q == ACK);        // Held while req_i stays high

    // --------------------------------------------------
    // Performance events
    // --------------------------------------------------
    // Atomics count as neither
    assign is_load_o  = (state_q == ISSUE) && (req.op == LOAD);
    assign is_store_o = (state_q == ISSUE) && (req.op == STORE);

endmodule

//--- dmem_pkg.sv
// --------------------------------------------------
// Types and widths shared by the data-memory path
// --------------------------------------------------
package dmem_pkg;

    localparam int XLEN   = 64;                 // Data width
    localparam int ADDR_W = 40;                 // Physical address width
    localparam int TAG_W  = 5;                  // Destination register tag

    localparam logic [31:0] IO_TOP = 32'h8000_0000;   // I/O window ends at 2 GB

    // CPU memory instructions
    typedef enum logic [4:0] {
        LB, LBU, LH, LHU, LW, LWU, LD,          // Loads
        SB, SH, SW, SD,                         // Stores
        AMO_SWAPW, AMO_SWAPD,
        AMO_ADDW,  AMO_ADDD,
        AMO_XORW,  AMO_XORD,
        AMO_ANDW,  AMO_ANDD,
        AMO_ORW,   AMO_ORD,
        AMO_MINW,  AMO_MIND,
        AMO_MAXW,  AMO_MAXD,
        AMO_MINWU, AMO_MINDU,
        AMO_MAXWU, AMO_MAXDU
    } mem_instr_e;

    // Cache operation codes
    typedef enum logic [3:0] {
        LOAD,
        STORE,
        AMO_SWAP,
        AMO_ADD,
        AMO_XOR,
        AMO_AND,
        AMO_OR,
        AMO_MIN,                                // Signed
        AMO_MAX,                                // Signed
        AMO_MINU,
        AMO_MAXU
    } dcache_op_e;

    // Access sequencing
    typedef enum logic [1:0] {
        IDLE,                                   // Waiting for req
        ISSUE,                                  // Request latched
        RESP,                                   // Memory access under way
        ACK                                     // Result held for the CPU
    } ctrl_state_e;

endpackage

//--- dmem_req_if.sv
// --------------------------------------------------
// Translated cache request from translator to memory
// --------------------------------------------------
interface dmem_req_if;
    import dmem_pkg::*;

    dcache_op_e        op;                      // Cache operation
    logic [ADDR_W-1:0] addr;
    logic [7:0]        be;                      // Byte enable, zero on loads
    logic [XLEN-1:0]   wdata;                   // Lane-aligned write data
    logic              word;                    // W-form atomic
    logic [1:0]        size;                    // log2 of bytes
    logic              sign;                    // Sign-extend the result
    logic [TAG_W-1:0]  tag;                     // Destination register

    // Translator side
    modport src (output op, addr, be, wdata, word, size, sign, tag);

    // Memory array and atomic unit
    modport mem (input op, addr, be, wdata, word);

    // Response path and control
    modport mon (input op, addr, size, sign, tag);

endinterface

//--- dmem_sva.sv
// --------------------------------------------------
// Handshake and event pulse assertions, bound into dmem_ctrl
// --------------------------------------------------
module dmem_sva (
    input logic                  clk_i,
    input logic                  rst_i,
    input logic                  req_i,
    input logic                  ack_i,
    input logic                  capture_i,
    input logic                  access_i,
    input logic                  is_load_i,
    input logic                  is_store_i,
    input dmem_pkg::ctrl_state_e state_i
);
    timeunit 1ns;
    timeprecision 100ps;
    import dmem_pkg::*;

    // Four-phase order
    a_ack_rise: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(ack_i) |-> req_i) else $error("ack_o rose without req_i");
    a_ack_fall: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(ack_i) |-> !$past(req_i)) else $error("ack_o fell before req_i dropped");

    // Memory answers one cycle after access
    a_resp_time: assert property (@(posedge clk_i) disable iff (rst_i)
        (state_i == ISSUE) |=> (state_i == RESP) ##1 (state_i == ACK))
        else $error("response did not arrive one cycle after access");

    // Event pulses
    a_evt_excl: assert property (@(posedge clk_i) disable iff (rst_i)
        !(is_load_i && is_store_i)) else $error("load and store events together");
    a_load_one: assert property (@(posedge clk_i) disable iff (rst_i)
        is_load_i |=> !is_load_i) else $error("is_load_o longer than one cycle");
    a_store_one: assert property (@(posedge clk_i) disable iff (rst_i)
        is_store_i |=> !is_store_i) else $error("is_store_o longer than one cycle");

    a_access: assert property (@(posedge clk_i) disable iff (rst_i)
        capture_i |=> access_i) else $error("access did not follow capture");

endmodule

bind dmem_ctrl dmem_sva dmem_sva_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (req_i),
    .ack_i      (ack_o),
    .capture_i  (capture_o),
    .access_i   (access_o),
    .is_load_i  (is_load_o),
    .is_store_i (is_store_o),
    .state_i    (state_q)
);

//--- dmem_top.sv
// --------------------------------------------------
// Data-memory unit top level, plain CPU-side ports
// --------------------------------------------------
module dmem_top #(
    parameter int MEM_WORDS = 256               // Memory depth, power of two
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    // Request side
    input  logic                        req_i,
    input  dmem_pkg::mem_instr_e        instr_i,
    input  logic [dmem_pkg::ADDR_W-1:0] addr_i,
    input  logic [dmem_pkg::XLEN-1:0]   wdata_i,
    input  logic [dmem_pkg::TAG_W-1:0]  rd_i,
    input  logic [dmem_pkg::ADDR_W-1:0] io_base_i,
    input  logic                        xlate_en_i,
    // Response side
    output logic                        ack_o,
    output logic [dmem_pkg::XLEN-1:0]   rdata_o,
    output logic [dmem_pkg::TAG_W-1:0]  rd_o,
    output logic                        io_o,
    // Performance counter events
    output logic                        is_load_o,
    output logic                        is_store_o
);
    import dmem_pkg::*;

    logic            capture;
    logic            access;
    logic            rsp_valid;
    logic [XLEN-1:0] rdata;                     // Old word from memory

    dmem_req_if req_if ();

    dmem_ctrl dmem_ctrl_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (req_i),
        .ack_o       (ack_o),
        .capture_o   (capture),
        .access_o    (access),
        .rsp_valid_i (rsp_valid),
        .req         (req_if.mon),
        .is_load_o   (is_load_o),
        .is_store_o  (is_store_o)
    );

    dcache_interface dcache_interface_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .capture_i   (capture),
        .instr_i     (instr_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .rd_i        (rd_i),
        .io_base_i   (io_base_i),
        .xlate_en_i  (xlate_en_i),
        .io_o        (io_o),
        .req         (req_if.src)
    );

    data_mem #(
        .MEM_WORDS   (MEM_WORDS)
    ) data_mem_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .access_i    (access),
        .req         (req_if.mem),
        .rsp_valid_o (rsp_valid),
        .rdata_o     (rdata)
    );

    load_align load_align_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .rsp_valid_i (rsp_valid),
        .rdata_i     (rdata),
        .req         (req_if.mon),
        .rdata_o     (rdata_o),
        .rd_o        (rd_o)
    );

endmodule

//--- dmem_unit.f
dmem_pkg.sv
dmem_req_if.sv
dcache_interface.sv
data_mem.sv
load_align.sv
dmem_ctrl.sv
dmem_top.sv
dmem_sva.sv
tb_dmem.sv

//--- load_align.sv
// --------------------------------------------------
// Aligns and extends returned data and holds it for the CPU
// --------------------------------------------------
module load_align (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       rsp_valid_i,
    input  logic [dmem_pkg::XLEN-1:0]  rdata_i,        // Old word from memory
    dmem_req_if.mon                    req,
    output logic [dmem_pkg::XLEN-1:0]  rdata_o,
    output logic [dmem_pkg::TAG_W-1:0] rd_o
);
    import dmem_pkg::*;

    logic [XLEN-1:0]  shifted;
    logic [XLEN-1:0]  value;
    logic [XLEN-1:0]  rdata_q;
    logic [TAG_W-1:0] rd_q;

    always_comb begin
        shifted = rdata_i >> {req.addr[2:0], 3'b0};    // Bring lane to bit 0
        case (req.size)
            2'd0: value = req.sign ? {{(XLEN-8){shifted[7]}}, shifted[7:0]}
                                   : XLEN'(shifted[7:0]);
            2'd1: value = req.sign ? {{(XLEN-16){shifted[15]}}, shifted[15:0]}
                                   : XLEN'(shifted[15:0]);
            2'd2: value = req.sign ? {{(XLEN-32){shifted[31]}}, shifted[31:0]}
                                   : XLEN'(shifted[31:0]);
            default: value = shifted;
        endcase
        if (req.op == STORE) begin
            value = '0;                                 // Stores return nothing
        end
    end

    // Held until the next response
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rdata_q <= '0;
            rd_q    <= '0;
        end else if (rsp_valid_i) begin
            rdata_q <= value;
            rd_q    <= req.tag;
        end
    end

    assign rdata_o = rdata_q;
    assign rd_o    = rd_q;

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the data-memory testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_dmem -f dmem_unit.f
./obj_dir/Vtb_dmem | tee sim.log
if grep -qF '*** TEST FAILED ***' sim.log; then
    exit 1
fi

//--- tb_dmem.sv
// --------------------------------------------------
// Random-request testbench for the data-memory unit
// Checks results, io flag, events and handshake against a model
// --------------------------------------------------
module tb_dmem;
    timeunit 1ns;
    timeprecision 100ps;
    import dmem_pkg::*;

    localparam int MEM_WORDS = 256;
    localparam int N_REQ     = 400;
    localparam int TIMEOUT   = 50;                      // Cycles allowed per wait
    localparam int ACK_EDGES = 3;                       // Accepting edge plus two
    localparam logic [ADDR_W-1:0] IO_BASE = 40'h00_4000_0000;

    logic              clk_i;
    logic              rst_i;
    logic              req_i;
    mem_instr_e        instr_i;
    logic [ADDR_W-1:0] addr_i;
    logic [XLEN-1:0]   wdata_i;
    logic [TAG_W-1:0]  rd_i;
    logic [ADDR_W-1:0] io_base_i;
    logic              xlate_en_i;
    logic              ack_o;
    logic [XLEN-1:0]   rdata_o;
    logic [TAG_W-1:0]  rd_o;
    logic              io_o;
    logic              is_load_o;
    logic              is_store_o;

    logic [XLEN-1:0] model_mem [MEM_WORDS];             // Reference memory
    logic [31:0]     rnd;
    int              err_val     = 0;
    int              err_proto   = 0;
    int              n_load_evt  = 0;
    int              n_store_evt = 0;
    bit              timed_out   = 1'b0;

    dmem_top #(
        .MEM_WORDS  (MEM_WORDS)
    ) dmem_top_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .req_i      (req_i),
        .instr_i    (instr_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .rd_i       (rd_i),
        .io_base_i  (io_base_i),
        .xlate_en_i (xlate_en_i),
        .ack_o      (ack_o),
        .rdata_o    (rdata_o),
        .rd_o       (rd_o),
        .io_o       (io_o),
        .is_load_o  (is_load_o),
        .is_store_o (is_store_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;                      // 4 ns period
    end

    // Event pulses sampled mid-cycle
    always @(negedge clk_i) begin
        if (is_load_o) n_load_evt++;
        if (is_store_o) n_store_evt++;
    end

    // --------------------------------------------------
    // Stimulus helpers and reference model
    // --------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic bit word_amo(input mem_instr_e ins);
        return ins inside {AMO_SWAPW, AMO_ADDW, AMO_XORW, AMO_ANDW, AMO_ORW,
                           AMO_MINW, AMO_MAXW, AMO_MINWU, AMO_MAXWU};
    endfunction

    function automatic int access_bytes(input mem_instr_e ins);
        if (ins inside {LB, LBU, SB}) return 1;
        if (ins inside {LH, LHU, SH}) return 2;
        if (ins inside {LW, LWU, SW} || word_amo(ins)) return 4;
        return 8;
    endfunction

    // Expected result of one request, model memory updated in place
    task automatic run_model(input mem_instr_e ins, input logic [ADDR_W-1:0] a,
                             input logic [XLEN-1:0] wd, output logic [XLEN-1:0] exp_data);
        int          idx;
        int          off;
        logic [63:0] old, nw, r64;
        logic [31:0] ol, sl, r32;
        idx      = int'(a[10:3]);
        off      = int'(a[2:0]);
        old      = model_mem[idx];
        nw       = old;
        ol       = old[8*off +: 32];                    // Only used for W atomics
        sl       = wd[31:0];
        r32      = '0;
        r64      = '0;
        exp_data = '0;                                  // Stores return zero
        case (ins)
            LB:        exp_data = {{56{old[8*off+7]}}, old[8*off +: 8]};
            LBU:       exp_data = {56'd0, old[8*off +: 8]};
            LH:        exp_data = {{48{old[8*off+15]}}, old[8*off +: 16]};
            LHU:       exp_data = {48'd0, old[8*off +: 16]};
            LW:        exp_data = {{32{old[8*off+31]}}, old[8*off +: 32]};
            LWU:       exp_data = {32'd0, old[8*off +: 32]};
            LD:        exp_data = old;
            SB:        nw[8*off +: 8] = wd[7:0];
            SH:        nw[8*off +: 16] = wd[15:0];
            SW:        nw[8*off +: 32] = wd[31:0];
            SD:        nw = wd;
            AMO_SWAPW: r32 = sl;
            AMO_ADDW:  r32 = ol + sl;
            AMO_XORW:  r32 = ol ^ sl;
            AMO_ANDW:  r32 = ol & sl;
            AMO_ORW:   r32 = ol | sl;
            AMO_MINW:  r32 = ($signed(ol) < $signed(sl)) ? ol : sl;
            AMO_MAXW:  r32 = ($signed(ol) > $signed(sl)) ? ol : sl;
            AMO_MINWU: r32 = (ol < sl) ? ol : sl;
            AMO_MAXWU: r32 = (ol > sl) ? ol : sl;
            AMO_SWAPD: r64 = wd;
            AMO_ADDD:  r64 = old + wd;
            AMO_XORD:  r64 = old ^ wd;
            AMO_ANDD:  r64 = old & wd;
            AMO_ORD:   r64 = old | wd;
            AMO_MIND:  r64 = ($signed(old) < $signed(wd)) ? old : wd;
            AMO_MAXD:  r64 = ($signed(old) > $signed(wd)) ? old : wd;
            AMO_MINDU: r64 = (old < wd) ? old : wd;
            AMO_MAXDU: r64 = (old > wd) ? old : wd;
            default: ;
        endcase
        if (word_amo(ins)) begin
            nw[8*off +: 32] = r32;                      // Other lane untouched
            exp_data        = {{32{ol[31]}}, ol};
        end else if (access_bytes(ins) == 8 && !(ins inside {LD, SD})) begin
            nw       = r64;                             // D-form atomic
            exp_data = old;
        end
        model_mem[idx] = nw;
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        mem_instr_e        ins;
        logic [ADDR_W-1:0] a;
        logic [XLEN-1:0]   wd, exp_data;
        logic [7:0]        wsel;
        logic [2:0]        off;
        logic              xl, exp_io, got;
        int                nb, edges, waits, hold, ld0, st0, exp_ld, exp_st;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = '0;                          // DUT array also starts cleared
        end
        rnd        = 32'haea1;
        rst_i      = 1'b1;
        req_i      = 1'b0;
        instr_i    = LB;
        addr_i     = '0;
        wdata_i    = '0;
        rd_i       = '0;
        io_base_i  = IO_BASE;
        xlate_en_i = 1'b0;
        repeat (3) @(posedge clk_i);
        rst_i <= 1'b0;

        for (int n = 0; n < N_REQ && !timed_out; n++) begin
            rnd  = xorshift(rnd);
            ins  = mem_instr_e'(5'(rnd % 29));
            nb   = access_bytes(ins);
            rnd  = xorshift(rnd);
            wsel = rnd[9] ? {5'd0, rnd[12:10]} : rnd[20:13];   // Hot 8 words half the time
            off  = rnd[2:0] & ~3'(nb - 1);              // Naturally aligned
            a    = {29'd0, wsel, off};
            if (rnd[22:21] == 2'd2) a[30] = 1'b1;       // Inside the I/O window
            if (rnd[22:21] == 2'd3) a[31] = 1'b1;       // At the window top
            xl   = rnd[23];
            hold = 1 + int'(rnd[31:30]);                // Extra cycles req stays high
            wd[63:32] = xorshift(rnd);
            rnd       = xorshift(wd[63:32]);
            wd[31:0]  = rnd;
            exp_io = (a >= IO_BASE) && (a < 40'h00_8000_0000) && !xl;
            exp_ld = (ins inside {LB, LBU, LH, LHU, LW, LWU, LD}) ? 1 : 0;
            exp_st = (ins inside {SB, SH, SW, SD}) ? 1 : 0;
            run_model(ins, a, wd, exp_data);

            @(posedge clk_i);
            req_i      <= 1'b1;
            instr_i    <= ins;
            addr_i     <= a;
            wdata_i    <= wd;
            rd_i       <= rnd[28:24];
            xlate_en_i <= xl;
            ld0   = n_load_evt;
            st0   = n_store_evt;
            edges = 0;
            got   = 1'b0;
            while (!got && edges < TIMEOUT) begin
                @(posedge clk_i);
                edges++;
                @(negedge clk_i);
                got = ack_o;
            end
            if (!got) begin
                $display("Timeout: ack_o never rose for request %0d", n);
                timed_out = 1'b1;
            end else begin
                if (edges != ACK_EDGES) begin
                    $display("ERR %0t ack_o edges got %0d exp %0d", $time, edges, ACK_EDGES);
                    err_proto++;
                end
                if (rdata_o !== exp_data) begin
                    $display("ERR %0t rdata_o got %h exp %h", $time, rdata_o, exp_data);
                    err_val++;
                end
                if (rd_o !== rd_i) begin
                    $display("ERR %0t rd_o got %h exp %h", $time, rd_o, rd_i);
                    err_val++;
                end
                if (io_o !== exp_io) begin
                    $display("ERR %0t io_o got %b exp %b", $time, io_o, exp_io);
                    err_val++;
                end
                // Back-pressure, ack must hold while req stays up
                repeat (hold) begin
                    @(posedge clk_i);
                    @(negedge clk_i);
                    if (!ack_o) begin
                        $display("ack_o fell at %0t while req_i was still high", $time);
                        err_proto++;
                    end
                end
                @(posedge clk_i);
                req_i <= 1'b0;
                waits = 0;
                while (got && waits < TIMEOUT) begin
                    @(posedge clk_i);
                    waits++;
                    @(negedge clk_i);
                    got = ack_o;
                end
                if (got) begin
                    $display("Timeout: ack_o stayed high after request %0d dropped", n);
                    timed_out = 1'b1;
                end
                if (n_load_evt - ld0 != exp_ld) begin
                    $display("ERR %0t is_load_o got %0d exp %0d", $time, n_load_evt - ld0, exp_ld);
                    err_proto++;
                end
                if (n_store_evt - st0 != exp_st) begin
                    $display("ERR %0t is_store_o got %0d exp %0d", $time,
                             n_store_evt - st0, exp_st);
                    err_proto++;
                end
            end
        end

        $display("Value errors %0d, protocol errors %0d, timeouts %0d",
                 err_val, err_proto, timed_out ? 1 : 0);
        if (err_val == 0 && err_proto == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
